// ==== hdl/buf_cfg_regs.sv ====
/* Control, credit allotment and status registers with sticky error bits */

`timescale 1ns/1ps

`include "buf_consts.svh"

module buf_cfg_regs (
        input  logic                     clk,
        input  logic                     rst_n,
        input  logic                     cfg_wr,
        input  logic [`BUF_REG_AW-1:0]   cfg_addr,
        input  logic [15:0]              cfg_wdata,
        output logic [15:0]              cfg_rdata,
        output buf_pkg::egr_cfg_t        egr_cfg,
        input  buf_pkg::buf_status_t     status
);

        logic             ctrl_enable;
        buf_pkg::credit_t crd_alloc;
        logic             crd_load;
        logic             sticky_ovf;
        logic             sticky_crd;
        logic             wr_ctrl;
        logic             wr_credit;
        logic             clr_sticky;

        // --------------------------------------------------
        // Write decode
        // --------------------------------------------------
        assign wr_ctrl    = cfg_wr && (cfg_addr == `BUF_REG_CTRL);
        assign wr_credit  = cfg_wr && (cfg_addr == `BUF_REG_CREDIT);
        // CTRL bit 1 is write-one-to-clear
        assign clr_sticky = wr_ctrl && cfg_wdata[1];

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        ctrl_enable <= 1'b0;
                        crd_alloc   <= buf_pkg::credit_t'(`BUF_EGR_CRD_RST);
                        crd_load    <= 1'b0;
                end else begin
                        if (wr_ctrl) begin
                                ctrl_enable <= cfg_wdata[0];
                        end
                        if (wr_credit) begin
                                crd_alloc <= cfg_wdata[`BUF_CRD_W-1:0];
                        end
                        // Load strobe lines up with the new allotment
                        crd_load <= wr_credit;
                end
        end

        // Sticky errors, a new pulse beats the clear
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        sticky_ovf <= 1'b0;
                        sticky_crd <= 1'b0;
                end else begin
                        sticky_ovf <= status.overflow | (sticky_ovf & ~clr_sticky);
                        sticky_crd <= status.credit_overrun | (sticky_crd & ~clr_sticky);
                end
        end

        assign egr_cfg.enable    = ctrl_enable;
        assign egr_cfg.crd_load  = crd_load;
        assign egr_cfg.crd_value = crd_alloc;

        // --------------------------------------------------
        // Read back
        // --------------------------------------------------
        always_comb begin
                cfg_rdata = '0;
                case (cfg_addr)
                        `BUF_REG_CTRL: cfg_rdata[0] = ctrl_enable;
                        `BUF_REG_CREDIT: cfg_rdata[`BUF_CRD_W-1:0] = crd_alloc;
                        `BUF_REG_STATUS: begin
                                cfg_rdata[3:0] = status.level;
                                cfg_rdata[4]   = sticky_ovf;
                                cfg_rdata[5]   = sticky_crd;
                        end
                        default: cfg_rdata = '0;
                endcase
        end

endmodule

// ==== hdl/buf_consts.svh ====
/* Widths, depth, credit reset value and register map of the credit buffer */

`ifndef BUF_CONSTS_SVH
`define BUF_CONSTS_SVH

// --------------------------------------------------
// Datapath
// --------------------------------------------------
`define BUF_DATA_W      16
`define BUF_DEPTH       6
// Address bits plus wrap MSB
`define BUF_PTR_W       4
// Fill level 0..depth
`define BUF_LVL_W       4
`define BUF_CRD_W       4
`define BUF_EGR_CRD_RST 2

// --------------------------------------------------
// Register map
// --------------------------------------------------
`define BUF_REG_AW      2
`define BUF_REG_CTRL    2'd0
`define BUF_REG_CREDIT  2'd1
`define BUF_REG_STATUS  2'd2

`endif

// ==== hdl/buf_pkg.sv ====
/* Shared vector types and packed structs of the credit buffer */

`include "buf_consts.svh"

package buf_pkg;

        // Plain vectors
        typedef logic [`BUF_DATA_W-1:0] data_t;
        typedef logic [`BUF_PTR_W-1:0]  ptr_t;
        typedef logic [`BUF_LVL_W-1:0]  level_t;
        typedef logic [`BUF_CRD_W-1:0]  credit_t;

        // One beat, payload plus last flag
        typedef struct packed {
                data_t data;
                logic  last;
        } beat_t;

        // Register block to egress controller
        typedef struct packed {
                logic    enable;
                logic    crd_load;   // single cycle
                credit_t crd_value;
        } egr_cfg_t;

        // Gathered at top, read back through STATUS
        typedef struct packed {
                level_t level;
                logic   overflow;        // pulse
                logic   credit_overrun;  // pulse
        } buf_status_t;

endpackage

// ==== hdl/counter_bin.sv ====
/* Binary FIFO pointer counter, wraps by clearing the low bits and toggling the MSB */

`timescale 1ns/1ps

`include "buf_consts.svh"

module counter_bin #(
        parameter int WIDTH = `BUF_PTR_W,
        parameter int MAX   = `BUF_DEPTH
) (
        input  logic         clk,
        input  logic         rst_n,
        input  logic         enable,
        output buf_pkg::ptr_t counter_bin_curr,
        output buf_pkg::ptr_t counter_bin_next
);

        // Last address before the wrap
        logic [WIDTH-2:0] last_addr;

        assign last_addr = (WIDTH-1)'(MAX - 1);

        // Next value offered combinationally
        always_comb begin
                if (!enable) begin
                        counter_bin_next = counter_bin_curr;
                end else if (counter_bin_curr[WIDTH-2:0] == last_addr) begin
                        // Wrap: flip MSB, low bits back to 0
                        counter_bin_next = {~counter_bin_curr[WIDTH-1], {(WIDTH-1){1'b0}}};
                end else begin
                        counter_bin_next = counter_bin_curr + 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        counter_bin_curr <= '0;
                end else begin
                        counter_bin_curr <= counter_bin_next;
                end
        end

endmodule

// ==== hdl/credit_buffer_top.sv ====
/* Credit buffer top, FIFO plus egress controller plus register block */

`timescale 1ns/1ps

`include "buf_consts.svh"

module credit_buffer_top (
        input  logic                     clk,
        input  logic                     rst_n,
        input  logic                     in_valid,
        input  buf_pkg::beat_t           in_beat,
        output logic                     in_credit,
        output logic                     out_valid,
        output buf_pkg::beat_t           out_beat,
        input  logic                     out_credit,
        input  logic                     cfg_wr,
        input  logic [`BUF_REG_AW-1:0]   cfg_addr,
        input  logic [15:0]              cfg_wdata,
        output logic [15:0]              cfg_rdata
);

        buf_pkg::beat_t       fifo_beat;
        logic                 fifo_empty;
        logic                 fifo_pop;
        buf_pkg::egr_cfg_t    egr_cfg;
        buf_pkg::buf_status_t status;

        // Ingress side, no full flag needed under credit flow
        fifo_sync u_fifo (
                .clk      (clk),
                .rst_n    (rst_n),
                .wr_en    (in_valid),
                .wr_beat  (in_beat),
                .rd_en    (fifo_pop),
                .rd_beat  (fifo_beat),
                .empty    (fifo_empty),
                .full     (),
                .level    (status.level),
                .overflow (status.overflow)
        );

        egress_credit_ctrl u_egress (
                .clk            (clk),
                .rst_n          (rst_n),
                .cfg            (egr_cfg),
                .fifo_empty     (fifo_empty),
                .fifo_beat      (fifo_beat),
                .fifo_pop       (fifo_pop),
                .out_credit     (out_credit),
                .out_valid      (out_valid),
                .out_beat       (out_beat),
                .in_credit      (in_credit),
                .credit_overrun (status.credit_overrun)
        );

        buf_cfg_regs u_regs (
                .clk       (clk),
                .rst_n     (rst_n),
                .cfg_wr    (cfg_wr),
                .cfg_addr  (cfg_addr),
                .cfg_wdata (cfg_wdata),
                .cfg_rdata (cfg_rdata),
                .egr_cfg   (egr_cfg),
                .status    (status)
        );

endmodule

// ==== hdl/egress_credit_ctrl.sv ====
/* Egress credit counter, pop decision, registered output beat and ingress
   credit return */

`timescale 1ns/1ps

`include "buf_consts.svh"

module egress_credit_ctrl (
        input  logic                 clk,
        input  logic                 rst_n,
        input  buf_pkg::egr_cfg_t    cfg,
        input  logic                 fifo_empty,
        input  buf_pkg::beat_t       fifo_beat,
        output logic                 fifo_pop,
        input  logic                 out_credit,
        output logic                 out_valid,
        output buf_pkg::beat_t       out_beat,
        output logic                 in_credit,
        output logic                 credit_overrun
);

        buf_pkg::credit_t crd_cnt;
        logic             crd_max;

        // --------------------------------------------------
        // Pop decision
        // --------------------------------------------------
        // Enabled, holding a credit, something queued
        assign fifo_pop = cfg.enable && (crd_cnt != '0) && !fifo_empty;

        assign crd_max = (crd_cnt == '1);

        // Grant that cannot be stored, counter already full
        assign credit_overrun = out_credit & ~fifo_pop & crd_max & ~cfg.crd_load;

        // --------------------------------------------------
        // Credit counter
        // --------------------------------------------------
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        crd_cnt <= buf_pkg::credit_t'(`BUF_EGR_CRD_RST);
                end else if (cfg.crd_load) begin
                        // Reload overrides grant and pop
                        crd_cnt <= cfg.crd_value;
                end else begin
                        case ({out_credit, fifo_pop})
                                2'b10: begin
                                        // Saturate at max
                                        if (!crd_max) begin
                                                crd_cnt <= crd_cnt + 1'b1;
                                        end
                                end
                                2'b01: crd_cnt <= crd_cnt - 1'b1;
                                // Grant and pop cancel
                                default: crd_cnt <= crd_cnt;
                        endcase
                end
        end

        // --------------------------------------------------
        // Output stage
        // --------------------------------------------------
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        out_valid <= 1'b0;
                        in_credit <= 1'b0;
                end else begin
                        out_valid <= fifo_pop;
                        // Freed entry goes back upstream with the beat
                        in_credit <= fifo_pop;
                end
        end

        // Beat payload, no reset
        always_ff @(posedge clk) begin
                if (fifo_pop) begin
                        out_beat <= fifo_beat;
                end
        end

endmodule

// ==== hdl/fifo_sync.sv ====
/* Synchronous beat FIFO with wrap-MSB pointers, full/empty, registered level
   and an overflow pulse */

`timescale 1ns/1ps

`include "buf_consts.svh"

module fifo_sync (
        input  logic                 clk,
        input  logic                 rst_n,
        input  logic                 wr_en,
        input  buf_pkg::beat_t       wr_beat,
        input  logic                 rd_en,
        output buf_pkg::beat_t       rd_beat,
        output logic                 empty,
        output logic                 full,
        output buf_pkg::level_t      level,
        output logic                 overflow
);

        localparam int ADDR_W = `BUF_PTR_W - 1;

        // --------------------------------------------------
        // Storage and pointers
        // --------------------------------------------------
        buf_pkg::beat_t mem [`BUF_DEPTH];

        buf_pkg::ptr_t wr_ptr;
        buf_pkg::ptr_t wr_ptr_next;
        buf_pkg::ptr_t rd_ptr;
        buf_pkg::ptr_t rd_ptr_next;
        logic          wr_accept;

        // Writes into a full FIFO are dropped
        assign wr_accept = wr_en & ~full;

        counter_bin #(
                .WIDTH (`BUF_PTR_W),
                .MAX   (`BUF_DEPTH)
        ) u_wr_ptr (
                .clk              (clk),
                .rst_n            (rst_n),
                .enable           (wr_accept),
                .counter_bin_curr (wr_ptr),
                .counter_bin_next (wr_ptr_next)
        );

        counter_bin #(
                .WIDTH (`BUF_PTR_W),
                .MAX   (`BUF_DEPTH)
        ) u_rd_ptr (
                .clk              (clk),
                .rst_n            (rst_n),
                .enable           (rd_en),
                .counter_bin_curr (rd_ptr),
                .counter_bin_next (rd_ptr_next)
        );

        // Payload array, no reset
        always_ff @(posedge clk) begin
                if (wr_accept) begin
                        mem[wr_ptr[ADDR_W-1:0]] <= wr_beat;
                end
        end

        // Read data straight from the read pointer
        assign rd_beat = mem[rd_ptr[ADDR_W-1:0]];

        // --------------------------------------------------
        // Flags
        // --------------------------------------------------
        assign empty = (wr_ptr == rd_ptr);
        assign full  = (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]) &&
                       (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]);

        // Beat lost on a full FIFO
        assign overflow = wr_en & full;

        // Entries between two pointers
        function automatic buf_pkg::level_t ptr_level(input buf_pkg::ptr_t wp,
                                                      input buf_pkg::ptr_t rp);
                buf_pkg::level_t wr_lo;
                buf_pkg::level_t rd_lo;
                wr_lo = buf_pkg::level_t'(wp[ADDR_W-1:0]);
                rd_lo = buf_pkg::level_t'(rp[ADDR_W-1:0]);
                // Same lap: plain difference
                if (wp[ADDR_W] == rp[ADDR_W]) begin
                        return wr_lo - rd_lo;
                end
                // Writer one lap ahead
                return buf_pkg::level_t'(`BUF_DEPTH) - rd_lo + wr_lo;
        endfunction

        // Level tracks the pointers as they land
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        level <= '0;
                end else begin
                        level <= ptr_level(wr_ptr_next, rd_ptr_next);
                end
        end

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/buf_pkg.sv
hdl/counter_bin.sv
hdl/fifo_sync.sv
hdl/egress_credit_ctrl.sv
hdl/buf_cfg_regs.sv
hdl/credit_buffer_top.sv
sim/tb_credit_buffer.sv

// ==== sim/tb_credit_buffer.sv ====
/* Credit buffer testbench with upstream and downstream credit models,
   register accesses, scoreboard queue and protocol assertions */

`timescale 1ns/1ps

`include "buf_consts.svh"

module tb_credit_buffer;

        localparam int MAX_CYCLES = 4000;
        localparam int RAND_BEATS = 40;
        localparam int DN_CAP     = 8;

        logic                   clk = 1'b0;
        logic                   rst_n;
        logic                   in_valid;
        buf_pkg::beat_t         in_beat;
        logic                   in_credit;
        logic                   out_valid;
        buf_pkg::beat_t         out_beat;
        logic                   out_credit;
        logic                   cfg_wr;
        logic [`BUF_REG_AW-1:0] cfg_addr;
        logic [15:0]            cfg_wdata;
        logic [15:0]            cfg_rdata;

        // Credit models and scoreboard
        int             up_credits     = `BUF_DEPTH;
        int             dn_outstanding = `BUF_EGR_CRD_RST;
        int             in_count       = 0;
        int             out_count      = 0;
        int             sent_count     = 0;
        int             cycle_cnt      = 0;
        logic           egr_enabled    = 1'b0;
        buf_pkg::beat_t exp_beat;
        buf_pkg::beat_t sb_q[$];

        credit_buffer_top u_credit_buffer_top (.*);

        always #4 clk = ~clk;

        // --------------------------------------------------
        // Error reporting
        // --------------------------------------------------
        task automatic stop_on_error(input string line);
                $display("%s", line);
                $display("Test failed");
                $fatal(1, "stopping at the first error");
        endtask

        task automatic fail_value(input string sig, input logic [31:0] exp,
                                  input logic [31:0] act);
                stop_on_error($sformatf("** Error at %0d ns: %s expected %0h, got %0h",
                                        $time, sig, exp, act));
        endtask

        // Beat must come back with its ingress credit
        a_credit_with_beat: assert property (@(posedge clk) disable iff (!rst_n)
                in_credit == out_valid)
                else fail_value("in_credit", $sampled(out_valid), $sampled(in_credit));
        // No beat without a granted credit
        a_granted: assert property (@(posedge clk) disable iff (!rst_n)
                out_valid |-> dn_outstanding > 0)
                else fail_value("dn_outstanding", 1, $sampled(dn_outstanding));
        a_hold: assert property (@(posedge clk) disable iff (!rst_n)
                out_valid |-> egr_enabled)
                else fail_value("out_valid", 0, $sampled(out_valid));
        // Upstream never gets more credits back than it owns
        a_up_credit: assert property (@(posedge clk) disable iff (!rst_n)
                in_credit |-> up_credits < `BUF_DEPTH)
                else fail_value("up_credits", `BUF_DEPTH - 1, $sampled(up_credits));

        // Scoreboard and credit return monitor
        always @(posedge clk) begin
                if (rst_n && in_credit) begin
                        in_count++;
                        up_credits++;
                end
                if (rst_n && out_valid) begin
                        out_count++;
                        dn_outstanding--;
                        assert (sb_q.size() != 0) begin
                                exp_beat = sb_q.pop_front();
                                assert (out_beat == exp_beat)
                                else fail_value("out_beat", exp_beat, out_beat);
                        end else begin
                                stop_on_error("out_valid with no beat left in the scoreboard");
                        end
                end
        end

        // Run limit
        always @(posedge clk) begin
                cycle_cnt++;
                if (cycle_cnt >= MAX_CYCLES) begin
                        stop_on_error("Timeout: run did not finish within the cycle limit");
                end
        end

        // --------------------------------------------------
        // Drivers start 1 ns after a rising edge
        // --------------------------------------------------
        task automatic tick();
                @(posedge clk);
                #1;
        endtask

        task automatic write_reg(input logic [`BUF_REG_AW-1:0] addr, input logic [15:0] data);
                cfg_wr    = 1'b1;
                cfg_addr  = addr;
                cfg_wdata = data;
                tick();
                cfg_wr    = 1'b0;
        endtask

        task automatic read_reg(input logic [`BUF_REG_AW-1:0] addr, output logic [15:0] data);
                cfg_addr = addr;
                @(negedge clk);
                data = cfg_rdata;
                tick();
        endtask

        task automatic check_status(input int lvl, input logic ovf, input logic ovr);
                logic [15:0] st;
                read_reg(`BUF_REG_STATUS, st);
                assert (st[3:0] == lvl) else fail_value("STATUS.level", lvl, st[3:0]);
                assert (st[4] == ovf) else fail_value("STATUS.overflow", ovf, st[4]);
                assert (st[5] == ovr) else fail_value("STATUS.credit_overrun", ovr, st[5]);
        endtask

        // Flag drops only once the last in-flight beat is out
        task automatic set_enable(input logic en);
                if (en) egr_enabled = 1'b1;
                write_reg(`BUF_REG_CTRL, {15'd0, en});
                if (!en) begin
                        repeat (2) tick();
                        egr_enabled = 1'b0;
                end
        endtask

        // Upstream sender spends one credit per beat
        task automatic send_beat(input logic use_credit);
                buf_pkg::beat_t b;
                b.data = buf_pkg::data_t'($urandom);
                b.last = 1'($urandom);
                while (use_credit && up_credits == 0) tick();
                in_valid = 1'b1;
                in_beat  = b;
                if (use_credit) begin
                        up_credits--;
                        sent_count++;
                        sb_q.push_back(b);
                end
                tick();
                in_valid = 1'b0;
        endtask

        task automatic grant_credit();
                out_credit = 1'b1;
                dn_outstanding++;
                tick();
                out_credit = 1'b0;
        endtask

        // Downstream receiver with random gaps until all beats are out
        task automatic grant_until_drained(ref bit done);
                while (!done || sb_q.size() != 0) begin
                        repeat ($urandom_range(3, 0)) tick();
                        if (dn_outstanding < DN_CAP) grant_credit();
                        else tick();
                end
                repeat (4) tick();
        endtask

        task automatic wait_drain();
                while (sb_q.size() != 0) tick();
                repeat (4) tick();
        endtask

        // --------------------------------------------------
        // Test sequence
        // --------------------------------------------------
        initial begin
                bit done;
                int start;
                void'($urandom(32'h2d39_1c13));
                rst_n      = 1'b0;
                in_valid   = 1'b0;
                in_beat    = '0;
                out_credit = 1'b0;
                cfg_wr     = 1'b0;
                cfg_addr   = '0;
                cfg_wdata  = '0;
                repeat (8) @(posedge clk);
                #1;
                rst_n = 1'b1;
                tick();

                // Hold with enable clear and then drain in order
                repeat (`BUF_DEPTH) send_beat(1'b1);
                tick();
                check_status(`BUF_DEPTH, 1'b0, 1'b0);
                set_enable(1'b1);
                done = 1'b1;
                grant_until_drained(done);

                // Random traffic over several pointer wraps
                done = 1'b0;
                fork
                        begin
                                repeat (RAND_BEATS) send_beat(1'b1);
                                done = 1'b1;
                        end
                        grant_until_drained(done);
                join

                // Reload with 3 credits and no grants
                set_enable(1'b0);
                repeat (`BUF_DEPTH) send_beat(1'b1);
                dn_outstanding = 3;
                write_reg(`BUF_REG_CREDIT, 16'd3);
                start = out_count;
                set_enable(1'b1);
                while (out_count < start + 3) tick();
                repeat (10) tick();
                assert (out_count == start + 3)
                else fail_value("out_valid count", start + 3, out_count);
                check_status(3, 1'b0, 1'b0);
                dn_outstanding = 5;
                write_reg(`BUF_REG_CREDIT, 16'd5);
                wait_drain();

                // Beat into a full FIFO is dropped and the flag stays until cleared
                set_enable(1'b0);
                repeat (`BUF_DEPTH) send_beat(1'b1);
                send_beat(1'b0);
                tick();
                check_status(`BUF_DEPTH, 1'b1, 1'b0);
                repeat (5) tick();
                check_status(`BUF_DEPTH, 1'b1, 1'b0);
                write_reg(`BUF_REG_CTRL, 16'h0002);
                check_status(`BUF_DEPTH, 1'b0, 1'b0);
                dn_outstanding = `BUF_DEPTH;
                write_reg(`BUF_REG_CREDIT, 16'(`BUF_DEPTH));
                set_enable(1'b1);
                wait_drain();

                // Grants past the counter maximum
                set_enable(1'b0);
                check_status(0, 1'b0, 1'b0);
                repeat ((1 << `BUF_CRD_W) + 1) grant_credit();
                tick();
                check_status(0, 1'b0, 1'b1);
                write_reg(`BUF_REG_CTRL, 16'h0002);
                check_status(0, 1'b0, 1'b0);

                // Totals
                assert (in_count == out_count)
                else fail_value("in_credit count", out_count, in_count);
                assert (out_count == sent_count)
                else fail_value("out_valid count", sent_count, out_count);
                $display("Test passed");
                $finish;
        end

endmodule
